// ==== testbench/rdTranCtrlInput.txt ====
# srcOp extDscrptr dataValidExtDscrptr extRdy priLvl srcAddr srcDataWidth numOfBytes outcome name
# Numbers in hex; outcome is done, error or both (done and error strobes in one cycle)
0 0 0 0 01 00001000 2 000100 done noOpPlain
1 0 0 0 01 10000000 3 000400 done intPri0
2 0 0 0 80 10002000 2 7fffff error intPri7
1 1 1 0 04 20000040 4 000080 done extValidPri2
3 1 0 1 10 30000000 5 001000 done extCheckReady
1 1 0 0 02 30001000 2 000200 done extCheckNotValid
1 0 0 0 06 40000000 3 000010 error intPriMulti
2 0 0 0 00 40000100 1 000001 done intPriZero
1 0 0 0 08 50000000 6 000800 both intDoneAndError
0 1 0 0 20 60000000 0 000000 done noOpExt
3 1 1 0 40 70000000 7 123456 error extValidPri6
2 1 0 1 20 7fff0000 2 000020 both extCheckBoth

// ==== sim.f ====
source/axiRdPkg.sv
source/dmaReqPkg.sv
source/tranCmdIf.sv
source/rdReqDecode.sv
source/rdTranSequencer.sv
source/rdStatusReport.sv
source/rdTranCtrl.sv
testbench/rdTranCtrl_sva.sv
testbench/rdTranCtrlTb.sv

// ==== Makefile ====
TOP = rdTranCtrlTb

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o simv

run: build
	./obj_dir/simv +verilator+error+limit+100

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== testbench/rdTranCtrlTb.sv ====
////////////////////////////////////////////////////////////
// Read transfer controller testbench
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdTranCtrlTb;

    localparam int NumPriLvls    = 8;
    localparam int TranSizeWidth = 23;
    localparam int Timeout       = 50;

    logic                       clock;
    logic                       resetn;
    logic                       reqInQueue;
    logic [NumPriLvls-1:0]      priLvl;
    logic                       extDscrptr;
    axiRdPkg::axiAddr_t         extDscrptrAddr;
    axiRdPkg::axiTranType_t     srcOp;
    axiRdPkg::axiDataWidth_t    srcDataWidth;
    axiRdPkg::axiAddr_t         srcAddr;
    logic [TranSizeWidth-1:0]   numOfBytes;
    logic                       dataValidExtDscrptr;
    logic                       rdyToAck;
    logic                       extRdyValid;
    logic                       extRdy;
    logic                       extRdyCheck;
    axiRdPkg::axiAddr_t         extDscrptrAddrFetch;
    logic                       rdTranDone;
    logic                       rdTranError;
    logic                       numOfBytesInRdValid;
    logic                       strtAXIRdTran;
    logic [TranSizeWidth-1:0]   srcNumOfBytes;
    axiRdPkg::axiTranType_t     srcAXITranType;
    axiRdPkg::axiDataWidth_t    srcAXIDataWidth;
    axiRdPkg::axiAddr_t         srcStrtAddr;
    axiRdPkg::axiBeats_t        srcMaxAXINumBeats;
    logic                       rdDoneAck;
    logic                       rdErrorAck;
    logic                       extDataValidNSetAck;
    logic                       noOpSrcAck;
    logic                       rdDone;
    logic                       rdError;
    logic                       extDataValidNSet;
    logic                       noOpSrc;
    logic [3:0]                 reports;
    string                      testName;
    string                      lines [$];
    int                         nextIndex;
    string                      pendingOutcome;
    string                      pendingName;
    logic                       pendingAnswer;

    // Report outputs as one vector with noOp on top and done at the bottom
    assign reports = {noOpSrc, extDataValidNSet, rdError, rdDone};

    rdTranCtrl #(
        .NumPriLvls     (NumPriLvls),
        .TranSizeWidth  (TranSizeWidth)
    ) dut_i (.*);

    always #20 clock = ~clock;

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkBit(input string what, input logic expected, input logic actual);
        assert (actual === expected)
        else
            stopWithFailure($sformatf("MISMATCH %s %s: expected %0b, actual %0b",
                testName, what, expected, actual));
    endtask

    task automatic checkField(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected)
        else
            stopWithFailure($sformatf("MISMATCH %s %s: expected %0h, actual %0h",
                testName, what, expected, actual));
    endtask

    // Advance one edge and look at what it produced
    task automatic nextCycle();
        @(posedge clock);
        #1;
        assert (dut_i.checks_i.violations == 0)
        else
            stopWithFailure($sformatf("Protocol assertion failed during test %s", testName));
    endtask

    function automatic axiRdPkg::axiBeats_t expectedBeats(input logic [NumPriLvls-1:0] pri);
        axiRdPkg::axiBeats_t beats;
        beats = axiRdPkg::PriBeats[axiRdPkg::NumPriBeats-1];
        if ($countones(pri) == 1)
        begin
            for (int n = 0; n < NumPriLvls; n++)
            begin
                if (pri[n])
                    beats = axiRdPkg::PriBeats[n];
            end
        end
        return beats;
    endfunction

    function automatic int unsigned randomDelay();
        return $urandom % 4;
    endfunction

    task automatic checkIdleCommand();
        checkBit("strtAXIRdTran", 1'b0, strtAXIRdTran);
        checkBit("extRdyCheck", 1'b0, extRdyCheck);
        checkField("extDscrptrAddrFetch", 64'(0), 64'(extDscrptrAddrFetch));
        checkField("srcStrtAddr", 64'(0), 64'(srcStrtAddr));
        checkField("srcAXITranType", 64'(0), 64'(srcAXITranType));
        checkField("srcAXIDataWidth", 64'(0), 64'(srcAXIDataWidth));
        checkField("srcNumOfBytes", 64'(0), 64'(srcNumOfBytes));
        checkField("srcMaxAXINumBeats", 64'(0), 64'(srcMaxAXINumBeats));
    endtask

    ////////////////////////////////////////////////////////////
    // Queue side
    ////////////////////////////////////////////////////////////
    // Put the next stimulus line on the queue outputs
    task automatic presentRequest();
        int count;
        count = $sscanf(lines[nextIndex], "%h %h %h %h %h %h %h %h %s %s", srcOp,
            extDscrptr, dataValidExtDscrptr, pendingAnswer, priLvl, srcAddr,
            srcDataWidth, numOfBytes, pendingOutcome, pendingName);
        assert (count == 10)
        else
            stopWithFailure($sformatf("Malformed stimulus line: %s", lines[nextIndex]));
        extDscrptrAddr = srcAddr ^ 32'h0f0f_0000;
        nextIndex++;
        reqInQueue = 1'b1;
    endtask

    // After an acknowledge the queue either offers its next entry at once or goes empty
    task automatic offerNextRequest();
        if (nextIndex < lines.size() && $urandom % 2 == 1)
            presentRequest();
        else
            reqInQueue = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Error controller side
    ////////////////////////////////////////////////////////////
    task automatic acknowledgeReport(input logic [3:0] expected);
        int cycles;
        repeat (randomDelay())
        begin
            nextCycle();
            checkField("held report", 64'(expected), 64'(reports));
            checkBit("rdyToAck", 1'b0, rdyToAck);
            checkIdleCommand();
        end
        {noOpSrcAck, extDataValidNSetAck, rdErrorAck, rdDoneAck} = expected;
        cycles = 0;
        do
        begin
            nextCycle();
            cycles++;
            checkBit("rdyToAck", 1'b0, rdyToAck);
            checkIdleCommand();
        end
        while (reports != 4'b0000 && cycles < Timeout);
        assert (reports == 4'b0000)
        else
            stopWithFailure($sformatf("Report of test %s never cleared", testName));
        checkField("report clear latency", 64'(1), 64'(cycles));
        {noOpSrcAck, extDataValidNSetAck, rdErrorAck, rdDoneAck} = 4'b0000;
        // Sequencer is back in idle after this edge
        nextCycle();
        checkBit("rdyToAck", 1'b0, rdyToAck);
        checkIdleCommand();
    endtask

    ////////////////////////////////////////////////////////////
    // Initiator side
    ////////////////////////////////////////////////////////////
    task automatic runTransfer(input string outcome);
        logic [3:0] expected;
        checkBit("strtAXIRdTran", 1'b1, strtAXIRdTran);
        checkBit("extRdyCheck", 1'b0, extRdyCheck);
        checkField("srcStrtAddr", 64'(srcAddr), 64'(srcStrtAddr));
        checkField("srcAXITranType", 64'(srcOp), 64'(srcAXITranType));
        checkField("srcAXIDataWidth", 64'(srcDataWidth), 64'(srcAXIDataWidth));
        checkField("srcNumOfBytes", 64'(numOfBytes), 64'(srcNumOfBytes));
        checkField("srcMaxAXINumBeats", 64'(expectedBeats(priLvl)), 64'(srcMaxAXINumBeats));
        repeat (randomDelay())
        begin
            nextCycle();
            checkIdleCommand();
            checkBit("rdyToAck", 1'b0, rdyToAck);
        end
        numOfBytesInRdValid = 1'b1;
        nextCycle();
        numOfBytesInRdValid = 1'b0;
        checkBit("rdyToAck", 1'b1, rdyToAck);
        checkIdleCommand();
        // Queue removes the acknowledged request
        offerNextRequest();
        repeat (randomDelay())
        begin
            nextCycle();
            checkBit("rdyToAck", 1'b0, rdyToAck);
            checkIdleCommand();
            checkField("early report", 64'(0), 64'(reports));
        end
        rdTranDone  = (outcome != "error");
        rdTranError = (outcome != "done");
        expected    = (outcome == "error") ? 4'b0010 : 4'b0001;
        nextCycle();
        rdTranDone  = 1'b0;
        rdTranError = 1'b0;
        checkField("report", 64'(expected), 64'(reports));
        acknowledgeReport(expected);
    endtask

    // Queue and fetch unit side of one request
    task automatic runRequest(input string outcome, input logic answer);
        nextCycle();
        if (srcOp == 2'b00)
        begin
            checkBit("rdyToAck", 1'b1, rdyToAck);
            checkIdleCommand();
            checkField("report", 64'(4'b1000), 64'(reports));
            offerNextRequest();
            acknowledgeReport(4'b1000);
        end
        else if (extDscrptr && !dataValidExtDscrptr)
        begin
            checkBit("extRdyCheck", 1'b1, extRdyCheck);
            checkField("extDscrptrAddrFetch", 64'(extDscrptrAddr), 64'(extDscrptrAddrFetch));
            repeat (randomDelay())
            begin
                nextCycle();
                checkBit("extRdyCheck", 1'b1, extRdyCheck);
                checkField("extDscrptrAddrFetch", 64'(extDscrptrAddr),
                    64'(extDscrptrAddrFetch));
                checkBit("strtAXIRdTran", 1'b0, strtAXIRdTran);
            end
            extRdyValid = 1'b1;
            extRdy      = answer;
            nextCycle();
            extRdyValid = 1'b0;
            extRdy      = 1'b0;
            if (answer)
                runTransfer(outcome);
            else
            begin
                checkBit("rdyToAck", 1'b1, rdyToAck);
                checkIdleCommand();
                checkField("report", 64'(4'b0100), 64'(reports));
                offerNextRequest();
                acknowledgeReport(4'b0100);
            end
        end
        else
            runTransfer(outcome);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        int    fd;
        int    numRequests;
        string line;
        clock               = 1'b0;
        resetn              = 1'b0;
        reqInQueue          = 1'b0;
        priLvl              = '0;
        extDscrptr          = 1'b0;
        extDscrptrAddr      = '0;
        srcOp               = '0;
        srcDataWidth        = '0;
        srcAddr             = '0;
        numOfBytes          = '0;
        dataValidExtDscrptr = 1'b0;
        extRdyValid         = 1'b0;
        extRdy              = 1'b0;
        rdTranDone          = 1'b0;
        rdTranError         = 1'b0;
        numOfBytesInRdValid = 1'b0;
        rdDoneAck           = 1'b0;
        rdErrorAck          = 1'b0;
        extDataValidNSetAck = 1'b0;
        noOpSrcAck          = 1'b0;
        testName            = "reset";
        numRequests         = 0;
        nextIndex           = 0;
        void'($urandom(32'ha07a_8e04));

        repeat (3) @(posedge clock);
        #1;
        checkIdleCommand();
        checkBit("rdyToAck", 1'b0, rdyToAck);
        checkField("reports", 64'(0), 64'(reports));
        resetn = 1'b1;
        nextCycle();
        checkIdleCommand();

        fd = $fopen("testbench/rdTranCtrlInput.txt", "r");
        if (fd == 0)
            stopWithFailure("Cannot open testbench/rdTranCtrlInput.txt");
        while ($fgets(line, fd) != 0)
        begin
            // Skip comments and blank lines
            if (line.len() >= 4 && line.getc(0) != 8'h23)
                lines.push_back(line);
        end
        $fclose(fd);

        while (reqInQueue || nextIndex < lines.size())
        begin
            // Queue was empty, so the next entry arrives after a gap
            if (!reqInQueue)
            begin
                repeat (randomDelay()) nextCycle();
                presentRequest();
            end
            testName = pendingName;
            runRequest(pendingOutcome, pendingAnswer);
            numRequests++;
        end

        if (numRequests > 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
            stopWithFailure("No request was found in the stimulus file");
    end

endmodule

`default_nettype wire

// ==== testbench/rdTranCtrl_sva.sv ====
////////////////////////////////////////////////////////////
// Read controller protocol assertions
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module protocolChecks (
    input  logic    clock,
    input  logic    resetn,
    input  logic    strtAXIRdTran,
    input  logic    rdyToAck,
    input  logic    extRdyCheck,
    input  logic    extRdyValid,
    input  logic    rdDone,
    input  logic    rdError,
    input  logic    extDataValidNSet,
    input  logic    noOpSrc
);

    // Failed assertions so far, read by the testbench
    int violations = 0;

    strtOneCycle: assert property (@(posedge clock) disable iff (!resetn)
        strtAXIRdTran |=> !strtAXIRdTran)
    else
    begin
        violations++;
        $error("strtAXIRdTran high for more than one cycle");
    end

    oneReportAtATime: assert property (@(posedge clock) disable iff (!resetn)
        $onehot0({rdDone, rdError, extDataValidNSet, noOpSrc}))
    else
    begin
        violations++;
        $error("more than one report output high");
    end

    // Fetch request held until the fetch unit answers
    checkHeld: assert property (@(posedge clock) disable iff (!resetn)
        extRdyCheck && !extRdyValid |=> extRdyCheck)
    else
    begin
        violations++;
        $error("extRdyCheck dropped before extRdyValid");
    end

    ackOneCycle: assert property (@(posedge clock) disable iff (!resetn)
        rdyToAck |=> !rdyToAck)
    else
    begin
        violations++;
        $error("rdyToAck high for more than one cycle");
    end

endmodule

bind rdTranCtrl protocolChecks checks_i (
    .clock              (clock),
    .resetn             (resetn),
    .strtAXIRdTran      (strtAXIRdTran),
    .rdyToAck           (rdyToAck),
    .extRdyCheck        (extRdyCheck),
    .extRdyValid        (extRdyValid),
    .rdDone             (rdDone),
    .rdError            (rdError),
    .extDataValidNSet   (extDataValidNSet),
    .noOpSrc            (noOpSrc)
);

`default_nettype wire

// ==== source/rdTranCtrl.sv ====
////////////////////////////////////////////////////////////
// DMA read transfer controller
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdTranCtrl #(
    parameter int NumPriLvls    = 8,
    parameter int TranSizeWidth = dmaReqPkg::DefTranSizeWidth
) (
    input  logic                        clock,
    input  logic                        resetn,
    // Transfer queue
    input  logic                        reqInQueue,
    input  logic [NumPriLvls-1:0]       priLvl,
    input  logic                        extDscrptr,
    input  axiRdPkg::axiAddr_t          extDscrptrAddr,
    input  axiRdPkg::axiTranType_t      srcOp,
    input  axiRdPkg::axiDataWidth_t     srcDataWidth,
    input  axiRdPkg::axiAddr_t          srcAddr,
    input  logic [TranSizeWidth-1:0]    numOfBytes,
    input  logic                        dataValidExtDscrptr,
    output logic                        rdyToAck,
    // Descriptor fetch unit
    input  logic                        extRdyValid,
    input  logic                        extRdy,
    output logic                        extRdyCheck,
    output axiRdPkg::axiAddr_t          extDscrptrAddrFetch,
    // AXI initiator
    input  logic                        rdTranDone,
    input  logic                        rdTranError,
    input  logic                        numOfBytesInRdValid,
    output logic                        strtAXIRdTran,
    output logic [TranSizeWidth-1:0]    srcNumOfBytes,
    output axiRdPkg::axiTranType_t      srcAXITranType,
    output axiRdPkg::axiDataWidth_t     srcAXIDataWidth,
    output axiRdPkg::axiAddr_t          srcStrtAddr,
    output axiRdPkg::axiBeats_t         srcMaxAXINumBeats,
    // Error controller
    input  logic                        rdDoneAck,
    input  logic                        rdErrorAck,
    input  logic                        extDataValidNSetAck,
    input  logic                        noOpSrcAck,
    output logic                        rdDone,
    output logic                        rdError,
    output logic                        extDataValidNSet,
    output logic                        noOpSrc
);

    logic                   post;
    dmaReqPkg::reportKind_t kind;
    logic                   busy;

    tranCmdIf #(.TranSizeWidth(TranSizeWidth)) cmdIf ();

    rdReqDecode #(
        .NumPriLvls         (NumPriLvls),
        .TranSizeWidth      (TranSizeWidth)
    ) decode_i (
        .srcOp              (srcOp),
        .extDscrptr         (extDscrptr),
        .dataValidExtDscrptr(dataValidExtDscrptr),
        .priLvl             (priLvl),
        .srcAddr            (srcAddr),
        .srcDataWidth       (srcDataWidth),
        .numOfBytes         (numOfBytes),
        .cmd                (cmdIf.decoder)
    );

    rdTranSequencer #(
        .TranSizeWidth      (TranSizeWidth)
    ) sequencer_i (
        .clock              (clock),
        .resetn             (resetn),
        .reqInQueue         (reqInQueue),
        .cmd                (cmdIf.sequencer),
        .extDscrptrAddr     (extDscrptrAddr),
        .extRdyValid        (extRdyValid),
        .extRdy             (extRdy),
        .numOfBytesInRdValid(numOfBytesInRdValid),
        .rdTranDone         (rdTranDone),
        .rdTranError        (rdTranError),
        .extRdyCheck        (extRdyCheck),
        .extDscrptrAddrFetch(extDscrptrAddrFetch),
        .strtAXIRdTran      (strtAXIRdTran),
        .srcNumOfBytes      (srcNumOfBytes),
        .srcAXITranType     (srcAXITranType),
        .srcAXIDataWidth    (srcAXIDataWidth),
        .srcStrtAddr        (srcStrtAddr),
        .srcMaxAXINumBeats  (srcMaxAXINumBeats),
        .rdyToAck           (rdyToAck),
        .post               (post),
        .kind               (kind),
        .busy               (busy)
    );

    rdStatusReport report_i (
        .clock              (clock),
        .resetn             (resetn),
        .post               (post),
        .kind               (kind),
        .rdDoneAck          (rdDoneAck),
        .rdErrorAck         (rdErrorAck),
        .extDataValidNSetAck(extDataValidNSetAck),
        .noOpSrcAck         (noOpSrcAck),
        .rdDone             (rdDone),
        .rdError            (rdError),
        .extDataValidNSet   (extDataValidNSet),
        .noOpSrc            (noOpSrc),
        .busy               (busy)
    );

endmodule

`default_nettype wire

// ==== source/rdStatusReport.sv ====
////////////////////////////////////////////////////////////
// Read status reporter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdStatusReport (
    input  logic                    clock,
    input  logic                    resetn,
    input  logic                    post,
    input  dmaReqPkg::reportKind_t  kind,
    input  logic                    rdDoneAck,
    input  logic                    rdErrorAck,
    input  logic                    extDataValidNSetAck,
    input  logic                    noOpSrcAck,
    output logic                    rdDone,
    output logic                    rdError,
    output logic                    extDataValidNSet,
    output logic                    noOpSrc,
    output logic                    busy
);

    // One flag per report kind, indexed by the kind encoding
    logic [dmaReqPkg::NumReportKinds-1:0] flags;
    logic [dmaReqPkg::NumReportKinds-1:0] acks;

    assign acks = {noOpSrcAck, extDataValidNSetAck, rdErrorAck, rdDoneAck};

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            flags <= '0;
        else
        begin
            for (int k = 0; k < dmaReqPkg::NumReportKinds; k++)
            begin
                if (post && (int'(kind) == k))
                    flags[k] <= 1'b1;
                else if (acks[k])
                    flags[k] <= 1'b0;
            end
        end
    end

    assign rdDone           = flags[dmaReqPkg::rptRdDone];
    assign rdError          = flags[dmaReqPkg::rptRdError];
    assign extDataValidNSet = flags[dmaReqPkg::rptExtNotValid];
    assign noOpSrc          = flags[dmaReqPkg::rptNoOp];

    // Sequencer holds off the next request while set
    assign busy = |flags;

endmodule

`default_nettype wire

// ==== source/rdTranSequencer.sv ====
////////////////////////////////////////////////////////////
// Read transfer sequencer
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdTranSequencer #(
    parameter int TranSizeWidth = dmaReqPkg::DefTranSizeWidth
) (
    input  logic                        clock,
    input  logic                        resetn,
    input  logic                        reqInQueue,
    tranCmdIf.sequencer                 cmd,
    input  axiRdPkg::axiAddr_t          extDscrptrAddr,
    input  logic                        extRdyValid,
    input  logic                        extRdy,
    input  logic                        numOfBytesInRdValid,
    input  logic                        rdTranDone,
    input  logic                        rdTranError,
    output logic                        extRdyCheck,
    output axiRdPkg::axiAddr_t          extDscrptrAddrFetch,
    output logic                        strtAXIRdTran,
    output logic [TranSizeWidth-1:0]    srcNumOfBytes,
    output axiRdPkg::axiTranType_t      srcAXITranType,
    output axiRdPkg::axiDataWidth_t     srcAXIDataWidth,
    output axiRdPkg::axiAddr_t          srcStrtAddr,
    output axiRdPkg::axiBeats_t         srcMaxAXINumBeats,
    output logic                        rdyToAck,
    output logic                        post,
    output dmaReqPkg::reportKind_t      kind,
    input  logic                        busy
);

    typedef enum logic [2:0] {
        idle,
        readyCheck,
        waitBytes,
        waitDone,
        waitReport
    } state_t;

    state_t state;
    state_t nextState;
    logic   launch;
    logic   checkReq;
    logic   ackReq;

    ////////////////////////////////////////////////////////////
    // Next state and decisions
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        nextState = state;
        launch    = 1'b0;
        checkReq  = 1'b0;
        ackReq    = 1'b0;
        post      = 1'b0;
        kind      = dmaReqPkg::rptNoOp;
        case (state)
            idle:
            begin
                if (reqInQueue)
                begin
                    case (cmd.reqClass)
                        dmaReqPkg::reqNoOp:
                        begin
                            ackReq    = 1'b1;
                            post      = 1'b1;
                            nextState = waitReport;
                        end
                        dmaReqPkg::reqExtCheck:
                        begin
                            checkReq  = 1'b1;
                            nextState = readyCheck;
                        end
                        default:
                        begin
                            launch    = 1'b1;
                            nextState = waitBytes;
                        end
                    endcase
                end
            end
            readyCheck:
            begin
                if (!extRdyValid)
                    checkReq = 1'b1;
                else if (extRdy)
                begin
                    launch    = 1'b1;
                    nextState = waitBytes;
                end
                else
                begin
                    // Descriptor still not valid, drop the request
                    ackReq    = 1'b1;
                    post      = 1'b1;
                    kind      = dmaReqPkg::rptExtNotValid;
                    nextState = waitReport;
                end
            end
            waitBytes:
            begin
                if (numOfBytesInRdValid)
                begin
                    ackReq    = 1'b1;
                    nextState = waitDone;
                end
            end
            waitDone:
            begin
                // Done has priority over error
                if (rdTranDone || rdTranError)
                begin
                    post      = 1'b1;
                    kind      = rdTranDone ? dmaReqPkg::rptRdDone : dmaReqPkg::rptRdError;
                    nextState = waitReport;
                end
            end
            waitReport:
            begin
                if (!busy)
                    nextState = idle;
            end
            default:
                nextState = idle;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Registered outputs
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            state               <= idle;
            extRdyCheck         <= 1'b0;
            extDscrptrAddrFetch <= '0;
            strtAXIRdTran       <= 1'b0;
            srcNumOfBytes       <= '0;
            srcAXITranType      <= '0;
            srcAXIDataWidth     <= '0;
            srcStrtAddr         <= '0;
            srcMaxAXINumBeats   <= '0;
            rdyToAck            <= 1'b0;
        end
        else
        begin
            state               <= nextState;
            extRdyCheck         <= checkReq;
            extDscrptrAddrFetch <= checkReq ? extDscrptrAddr : '0;
            rdyToAck            <= ackReq;
            // Command fields only carry data in the start cycle
            strtAXIRdTran       <= launch;
            srcNumOfBytes       <= launch ? cmd.numBytes : '0;
            srcAXITranType      <= launch ? cmd.tranType : '0;
            srcAXIDataWidth     <= launch ? cmd.dataWidth : '0;
            srcStrtAddr         <= launch ? cmd.startAddr : '0;
            srcMaxAXINumBeats   <= launch ? cmd.maxBeats : '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/rdReqDecode.sv ====
////////////////////////////////////////////////////////////
// Read request decoder
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rdReqDecode #(
    parameter int NumPriLvls    = 8,
    parameter int TranSizeWidth = dmaReqPkg::DefTranSizeWidth
) (
    input  axiRdPkg::axiTranType_t      srcOp,
    input  logic                        extDscrptr,
    input  logic                        dataValidExtDscrptr,
    input  logic [NumPriLvls-1:0]       priLvl,
    input  axiRdPkg::axiAddr_t          srcAddr,
    input  axiRdPkg::axiDataWidth_t     srcDataWidth,
    input  logic [TranSizeWidth-1:0]    numOfBytes,
    tranCmdIf.decoder                   cmd
);

    localparam logic [NumPriLvls-1:0] PriOne = 1;

    // Request class
    always_comb
    begin
        if (srcOp == axiRdPkg::TranTypeNoOp)
            cmd.reqClass = dmaReqPkg::reqNoOp;
        else if (!extDscrptr)
            cmd.reqClass = dmaReqPkg::reqInternal;
        else if (dataValidExtDscrptr)
            cmd.reqClass = dmaReqPkg::reqExtValid;
        else
            cmd.reqClass = dmaReqPkg::reqExtCheck;
    end

    // Priority to beat limit, anything not one-hot gets the last entry
    always_comb
    begin
        cmd.maxBeats = axiRdPkg::PriBeats[axiRdPkg::NumPriBeats-1];
        for (int n = 0; n < NumPriLvls; n++)
        begin
            if (priLvl == (PriOne << n))
                cmd.maxBeats = axiRdPkg::PriBeats[n];
        end
    end

    assign cmd.startAddr = srcAddr;
    assign cmd.tranType  = srcOp;
    assign cmd.dataWidth = srcDataWidth;
    assign cmd.numBytes  = numOfBytes;

endmodule

`default_nettype wire

// ==== source/tranCmdIf.sv ====
////////////////////////////////////////////////////////////
// Decoded transfer command
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface tranCmdIf #(
    parameter int TranSizeWidth = dmaReqPkg::DefTranSizeWidth
);

    dmaReqPkg::reqClass_t       reqClass;
    axiRdPkg::axiAddr_t         startAddr;
    axiRdPkg::axiTranType_t     tranType;
    axiRdPkg::axiDataWidth_t    dataWidth;
    logic [TranSizeWidth-1:0]   numBytes;
    axiRdPkg::axiBeats_t        maxBeats;

    modport decoder (
        output reqClass, startAddr, tranType, dataWidth, numBytes, maxBeats
    );

    modport sequencer (
        input reqClass, startAddr, tranType, dataWidth, numBytes, maxBeats
    );

endinterface

`default_nettype wire

// ==== source/dmaReqPkg.sv ====
////////////////////////////////////////////////////////////
// Queue request and report kinds
////////////////////////////////////////////////////////////
`default_nettype none

package dmaReqPkg;

    // Byte count width used unless the top level overrides it
    localparam int DefTranSizeWidth = 23;

    // How a queue request is handled
    typedef enum logic [1:0] {
        reqNoOp,
        reqInternal,
        reqExtValid,
        reqExtCheck
    } reqClass_t;

    // Reports towards the error controller
    localparam int NumReportKinds = 4;
    typedef enum logic [1:0] {
        rptRdDone,
        rptRdError,
        rptExtNotValid,
        rptNoOp
    } reportKind_t;

endpackage

`default_nettype wire

// ==== source/axiRdPkg.sv ====
////////////////////////////////////////////////////////////
// AXI read command definitions
////////////////////////////////////////////////////////////
`default_nettype none

package axiRdPkg;

    // Byte address of a read source
    localparam int AddrWidth = 32;
    typedef logic [AddrWidth-1:0] axiAddr_t;

    // Source operation, also the AXI transfer type
    typedef logic [1:0] axiTranType_t;
    localparam axiTranType_t TranTypeNoOp = 2'b00;

    // Data-width code
    typedef logic [2:0] axiDataWidth_t;

    // Beat limit per burst
    localparam int BeatsWidth = 8;
    typedef logic [BeatsWidth-1:0] axiBeats_t;

    // Beat limit by one-hot priority position, highest priority first
    localparam int NumPriBeats = 8;
    localparam axiBeats_t PriBeats [NumPriBeats] = '{
        8'd255, 8'd127, 8'd63, 8'd31, 8'd15, 8'd7, 8'd3, 8'd0
    };

endpackage

`default_nettype wire
